// File: routerOutputPort_stimulus.txt
# F port flitId length payload : port decimal, other fields hex; length counts only in headers
# P mask : outReady for 32 cycles, bit 31 first; random stalls follow the last pattern
P 00000000
P AAAAAAAA
P FFFF00FF
F 0 1 003 1001
F 0 2 000 1002
F 0 2 000 1003
F 0 4 000 1004
F 0 1 002 1005
F 0 4 000 1006
F 1 1 002 2001
F 1 2 000 2002
F 1 4 000 2003
F 1 1 001 2004
F 1 4 000 2005
F 2 1 004 3001
F 2 2 000 3002
F 2 2 000 3003
F 2 2 000 3004
F 2 4 000 3005
F 3 1 001 4001
F 3 4 000 4002
F 3 1 001 4003
F 3 2 000 4004
F 3 4 000 4005
F 4 1 002 5001
F 4 2 000 5002
F 4 2 000 5003
F 4 2 000 5004
F 4 2 000 5005
F 4 2 000 5006
F 4 2 000 5007
F 4 2 000 5008
F 4 4 000 5009

// File: routerOutputPort.f
nocArbPkg.sv
flitFifo.sv
grantTimer.sv
outputArbiter.sv
outputStage.sv
routerOutputPort.sv
routerOutputPort_assertions.sv
tbRouterOutputPort.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbRouterOutputPort
FILELIST  ?= routerOutputPort.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tbRouterOutputPort.sv
`timescale 1ns/100ps

module tbRouterOutputPort;
  import nocArbPkg::*;

  localparam int    FIFO_DEPTH = 4;
  localparam int    CLK_PERIOD = 40;
  localparam string STIM_FILE  = "routerOutputPort_stimulus.txt";

  logic                 clk;
  logic                 rst;
  logic [NUM_PORTS-1:0] inValid;
  flitT                 inFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] inReady;
  logic                 outValid;
  outFlitT              outFlit;
  logic                 outReady;

  flitT        sendQ [NUM_PORTS][$];
  flitT        expQ [NUM_PORTS][$];
  logic [31:0] patterns [$];
  int          outHist [$];
  int          fileCnt [NUM_PORTS];
  int          outCnt [NUM_PORTS];
  int          waitSince [NUM_PORTS];
  pktLenT      lastHdrLen [NUM_PORTS];
  int          totalFlits;
  bit          loaded;
  int          mismatchCount;
  int          failCount;
  int          cycle;
  int          afterRst;
  int          patCycle;
  int          seed = 32'h8f9392f9;
  int          lastSrc = -1;
  int          runCount;
  int          runMax;
  bit          prevStall;
  outFlitT     prevFlit;
  bit          sawFull;
  bit          done;

  routerOutputPort #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      mismatchCount++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic reportFailure(input string what);
    failCount++;
    $display("%0t ns: %s", $time, what);
  endtask

  task automatic loadStimulus;
    int          fd;
    int          code;
    int          port;
    logic [31:0] id;
    logic [31:0] len;
    logic [31:0] pl;
    logic [31:0] mask;
    string       line;
    flitT        f;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      reportFailure("cannot open the stimulus file");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      code = $fgets(line, fd);
      if (line.len() < 2)
        continue;
      if (line[0] == "F")
      begin
        code = $sscanf(line, "F %d %h %h %h", port, id, len, pl);
        if (code != 4 || port < 0 || port >= NUM_PORTS)
        begin
          reportFailure("bad flit line in the stimulus file");
          continue;
        end
        f.flitId  = id[2:0];
        f.length  = len[11:0];
        f.payload = pl[15:0];
        sendQ[port].push_back(f);
        fileCnt[port]++;
        totalFlits++;
      end
      else if (line[0] == "P")
      begin
        code = $sscanf(line, "P %h", mask);
        patterns.push_back(mask);
      end
    end
    $fclose(fd);
  endtask

  function automatic bit othersWaiting(input int p);
    othersWaiting = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++)
    begin
      if (q != p && expQ[q].size() > 0)
        othersWaiting = 1'b1;
    end
  endfunction

  // Ports between p and q must not have been passed over. The grant to q
  // was decided no earlier than one cycle after the output two places
  // before p's last flit, so only ports waiting since then count
  task automatic checkRotation(input int p, input int q);
    int t;
    int j;
    if (outHist.size() < 3)
      return;
    t = outHist[outHist.size() - 3];
    j = (p + 1) % NUM_PORTS;
    while (j != q)
    begin
      if (expQ[j].size() > 0 && outCnt[j] > 0 && waitSince[j] <= t)
        reportFailure($sformatf("rotation from port %0d to port %0d passed over waiting port %0d",
                                p, q, j));
      j = (j + 1) % NUM_PORTS;
    end
  endtask

  task automatic handleOutput;
    int   src;
    flitT e;
    src = int'(outFlit.srcPort);
    if (src >= NUM_PORTS)
    begin
      reportFailure("output flit has an invalid source port");
      return;
    end
    if (expQ[src].size() == 0)
    begin
      reportFailure($sformatf("flit from port %0d that had nothing queued", src));
      return;
    end
    e = expQ[src].pop_front();
    checkValue("outFlit.flit.flitId", 64'(outFlit.flit.flitId), 64'(e.flitId));
    checkValue("outFlit.flit.length", 64'(outFlit.flit.length), 64'(e.length));
    checkValue("outFlit.flit.payload", 64'(outFlit.flit.payload), 64'(e.payload));
    if (e.flitId == FLIT_HEADER)
      lastHdrLen[src] = e.length;
    if (src != lastSrc)
    begin
      if (lastSrc >= 0)
        checkRotation(lastSrc, src);
      runCount = 0;
      runMax   = int'(lastHdrLen[src]);
    end
    if (int'(lastHdrLen[src]) > runMax)
      runMax = int'(lastHdrLen[src]);
    // Tenure of L+1 pops, plus slack for the skid entries and request lag
    if (othersWaiting(src))
      runCount++;
    else
      runCount = 0;
    if (runCount > runMax + 4)
      reportFailure($sformatf("port %0d kept the output too long while others waited", src));
    lastSrc = src;
    outCnt[src]++;
    outHist.push_back(cycle);
  endtask

  always @(posedge clk)
  begin
    cycle++;
    if (rst)
    begin
      afterRst = 0;
      prevStall = 1'b0;
      // Registers are unknown until the first reset edge
      if (cycle > 1)
      begin
        checkValue("outValid", 64'(outValid), 64'd0);
        checkValue("inReady", 64'(inReady), 64'd0);
      end
    end
    else
    begin
      afterRst++;
      if (afterRst == 1)
        checkValue("outValid", 64'(outValid), 64'd0);
      // Every FIFO is empty, so all inputs are ready in the first cycle after reset
      if (afterRst == 2)
        checkValue("inReady", 64'(inReady), 64'({NUM_PORTS{1'b1}}));
      if (prevStall)
      begin
        checkValue("outValid", 64'(outValid), 64'd1);
        checkValue("outFlit", 64'(outFlit), 64'(prevFlit));
      end
      if (outValid && outReady)
        handleOutput();
      prevStall = outValid && !outReady;
      prevFlit  = outFlit;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (inValid[p] && !inReady[p] && afterRst > 1)
          sawFull = 1'b1;
        if (inValid[p] && inReady[p] && sendQ[p].size() > 0)
        begin
          if (expQ[p].size() == 0)
            waitSince[p] = cycle;
          expQ[p].push_back(sendQ[p].pop_front());
        end
      end
    end
  end

  task automatic driveInputs;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inValid[p] = (sendQ[p].size() > 0);
      inFlit[p]  = (sendQ[p].size() > 0) ? sendQ[p][0] : '0;
    end
    // Patterns first, 32 cycles each, then random stalls
    if (patCycle < patterns.size() * 32)
      outReady = patterns[patCycle / 32][31 - (patCycle % 32)];
    else
      outReady = (($random(seed) & 3) != 0);
    patCycle++;
  endtask

  function automatic bit allDrained;
    allDrained = !outValid;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (sendQ[p].size() > 0 || expQ[p].size() > 0)
        allDrained = 1'b0;
    end
  endfunction

  initial
  begin
    rst      = 1'b1;
    inValid  = '0;
    outReady = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
      inFlit[p] = '0;
    loadStimulus();
    loaded = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      driveInputs();
      done = allDrained();
    end
    for (int p = 0; p < NUM_PORTS; p++)
      checkValue($sformatf("outCount[%0d]", p), 64'(outCnt[p]), 64'(fileCnt[p]));
    if (!sawFull)
      reportFailure("no input FIFO ever filled up under back-pressure");
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    if (mismatchCount == 0 && failCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #(CLK_PERIOD * (totalFlits * 8 + 200));
    $display("timeout: the output did not deliver every flit in time");
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: routerOutputPort_assertions.sv
`timescale 1ns/100ps

module routerOutputPort_assertions (
  input logic                             clk,
  input logic                             rst,
  input nocArbPkg::portIdT                grant,
  input logic                             grantValid,
  input logic [nocArbPkg::NUM_PORTS-1:0] req,
  input logic [nocArbPkg::NUM_PORTS-1:0] timesUp,
  input logic [nocArbPkg::NUM_PORTS-1:0] runTimer
);
  import nocArbPkg::*;

  logic holdGrant;

  assign holdGrant = grantValid && req[grant] && !timesUp[grant];

  // The arbiter only drops the grant when no port was requesting
  idleOnlyWithoutReq: assert property (@(posedge clk) disable iff (rst)
    !grantValid |-> ($past(req) == '0))
    else $error("arbiter went idle while a port was requesting");

  // A held grant may only move once the request drops or the timer expires
  grantStable: assert property (@(posedge clk) disable iff (rst)
    !$stable(grant) |-> !$past(holdGrant))
    else $error("grant changed while the granted port still held its tenure");

  // At most one timer runs, and only for the port that holds the grant
  timerFollowsHold: assert property (@(posedge clk) disable iff (rst)
    runTimer == (holdGrant ? (NUM_PORTS'(1) << grant) : '0))
    else $error("runTimer does not match the held grant");

endmodule

bind outputArbiter routerOutputPort_assertions uAssert (
  .clk        (clk),
  .rst        (rst),
  .grant      (grant),
  .grantValid (grantValid),
  .req        (req),
  .timesUp    (timesUp),
  .runTimer   (runTimer)
);

// File: routerOutputPort.sv
`timescale 1ns/100ps

module routerOutputPort #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [nocArbPkg::NUM_PORTS-1:0] inValid,
  input  nocArbPkg::flitT                 inFlit [nocArbPkg::NUM_PORTS],
  output logic [nocArbPkg::NUM_PORTS-1:0] inReady,
  output logic                             outValid,
  output nocArbPkg::outFlitT              outFlit,
  input  logic                             outReady
);
  import nocArbPkg::*;

  logic [NUM_PORTS-1:0] headValid;
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] timesUp;
  logic [NUM_PORTS-1:0] runTimer;
  flitT                 headFlit [NUM_PORTS];
  portIdT               grant;
  logic                 grantValid;

  // One FIFO and one tenure timer per input port
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gInput
    flitFifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) uFifo (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[i]),
      .inFlit    (inFlit[i]),
      .inReady   (inReady[i]),
      .pop       (pop[i]),
      .headValid (headValid[i]),
      .headFlit  (headFlit[i])
    );

    grantTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .xfer       (pop[i]),
      .xferFlitId (headFlit[i].flitId),
      .xferLength (headFlit[i].length),
      .runTimer   (runTimer[i]),
      .timesUp    (timesUp[i])
    );
  end

  outputArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (headValid),
    .timesUp    (timesUp),
    .grant      (grant),
    .grantValid (grantValid),
    .runTimer   (runTimer)
  );

  outputStage uStage (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .grantValid (grantValid),
    .headValid  (headValid),
    .headFlit   (headFlit),
    .pop        (pop),
    .outValid   (outValid),
    .outFlit    (outFlit),
    .outReady   (outReady)
  );

endmodule

// File: outputStage.sv
`timescale 1ns/100ps

module outputStage (
  input  logic                             clk,
  input  logic                             rst,
  input  nocArbPkg::portIdT               grant,
  input  logic                             grantValid,
  input  logic [nocArbPkg::NUM_PORTS-1:0] headValid,
  input  nocArbPkg::flitT                 headFlit [nocArbPkg::NUM_PORTS],
  output logic [nocArbPkg::NUM_PORTS-1:0] pop,
  output logic                             outValid,
  output nocArbPkg::outFlitT              outFlit,
  input  logic                             outReady
);
  import nocArbPkg::*;

  outFlitT    skidBuf [2];
  outFlitT    selFlit;
  logic       wrPtr;
  logic       rdPtr;
  logic [1:0] used;
  logic       room;
  logic       load;
  logic       unload;

  // Room does not depend on outReady, so pop has no path from the sink
  assign room = (used != 2'd2);

  always_comb
  begin
    pop             = '0;
    selFlit.flit    = headFlit[0];
    selFlit.srcPort = grant;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant == portIdT'(i))
      begin
        selFlit.flit = headFlit[i];
        pop[i]       = grantValid && headValid[i] && room;
      end
    end
  end

  assign load   = |pop;
  assign unload = outValid && outReady;

  always_ff @(posedge clk)
  begin
    if (load)
      skidBuf[wrPtr] <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      used  <= 2'd0;
    end
    else
    begin
      if (load)
        wrPtr <= ~wrPtr;
      if (unload)
        rdPtr <= ~rdPtr;
      used <= used + 2'(load) - 2'(unload);
    end
  end

  // Head entry stays put until the sink takes it
  assign outValid = (used != 2'd0);
  assign outFlit  = skidBuf[rdPtr];

endmodule

// File: outputArbiter.sv
`timescale 1ns/100ps

module outputArbiter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [nocArbPkg::NUM_PORTS-1:0] req,
  input  logic [nocArbPkg::NUM_PORTS-1:0] timesUp,
  output nocArbPkg::portIdT               grant,
  output logic                             grantValid,
  output logic [nocArbPkg::NUM_PORTS-1:0] runTimer
);
  import nocArbPkg::*;

  arbStateT state;
  arbStateT nextState;

  function automatic arbStateT stateOf(portIdT p);
    case (p)
      PORT_L:  stateOf = GRANT_L;
      PORT_N:  stateOf = GRANT_N;
      PORT_E:  stateOf = GRANT_E;
      PORT_W:  stateOf = GRANT_W;
      PORT_S:  stateOf = GRANT_S;
      default: stateOf = IDLE;
    endcase
  endfunction

  function automatic portIdT portOf(arbStateT s);
    case (s)
      GRANT_N: portOf = PORT_N;
      GRANT_E: portOf = PORT_E;
      GRANT_W: portOf = PORT_W;
      GRANT_S: portOf = PORT_S;
      default: portOf = PORT_L;
    endcase
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
      grant <= PORT_L;
    end
    else
    begin
      state <= nextState;
      // Keep the last port number while idle
      if (nextState != IDLE)
        grant <= portOf(nextState);
    end
  end

  assign grantValid = (state != IDLE);

  always_comb
  begin
    int cur;
    int idx;
    nextState = IDLE;
    runTimer  = '0;
    cur       = int'(portOf(state));
    idx       = 0;

    if (state == IDLE)
    begin
      // Fixed order L, N, E, W, S, scanned so the lowest port wins
      for (int k = NUM_PORTS - 1; k >= 0; k--)
      begin
        if (req[k])
          nextState = stateOf(portIdT'(k));
      end
    end
    else if (req[cur] && !timesUp[cur])
    begin
      // Hold the grant and let the tenure timer run
      runTimer[cur] = 1'b1;
      nextState     = state;
    end
    else
    begin
      // Rotate: p+1 has the highest priority, p itself the lowest
      for (int k = NUM_PORTS; k >= 1; k--)
      begin
        idx = (cur + k) % NUM_PORTS;
        if (req[idx])
          nextState = stateOf(portIdT'(idx));
      end
    end
  end

endmodule

// File: grantTimer.sv
`timescale 1ns/100ps

module grantTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              xfer,
  input  nocArbPkg::flitIdT xferFlitId,
  input  nocArbPkg::pktLenT xferLength,
  input  logic              runTimer,
  output logic              timesUp
);
  import nocArbPkg::*;

  pktLenT limit;
  pktLenT xferCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit     <= '0;
      xferCount <= '0;
    end
    else
    begin
      // Latest header decides the tenure length
      if (xfer && (xferFlitId == FLIT_HEADER))
        limit <= xferLength;

      if (!runTimer)
        xferCount <= '0;
      else if (xfer)
        xferCount <= xferCount + 1'b1;
    end
  end

  // Limit of 0 matches right away, so the tenure lasts one cycle
  assign timesUp = (xferCount == limit);

endmodule

// File: flitFifo.sv
`timescale 1ns/100ps

module flitFifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  input  nocArbPkg::flitT inFlit,
  output logic            inReady,
  input  logic            pop,
  output logic            headValid,
  output nocArbPkg::flitT headFlit
);
  import nocArbPkg::*;

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

  flitT              mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wrPtr;
  logic [ADDR_W-1:0] rdPtr;
  logic [CNT_W-1:0]  used;
  logic [CNT_W-1:0]  nextUsed;
  logic              push;
  logic              take;

  assign push      = inValid && inReady;
  assign take      = pop && headValid;
  assign headValid = (used != '0);
  assign headFlit  = mem[rdPtr];
  assign nextUsed  = used + CNT_W'(push) - CNT_W'(take);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      used    <= '0;
      inReady <= 1'b0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (take)
        rdPtr <= (rdPtr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      used <= nextUsed;
      // Registered so the input side sees no path from pop
      inReady <= (nextUsed != CNT_W'(FIFO_DEPTH));
    end
  end

endmodule

// File: nocArbPkg.sv
package nocArbPkg;

  localparam int NUM_PORTS = 5;

  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] pktLenT;
  typedef logic [15:0] payloadT;
  typedef logic [2:0]  portIdT;

  // Flit type codes, one-hot
  localparam flitIdT FLIT_HEADER = 3'b001;
  localparam flitIdT FLIT_BODY   = 3'b010;
  localparam flitIdT FLIT_TAIL   = 3'b100;

  // Length only carries meaning in a header flit
  typedef struct packed {
    flitIdT  flitId;
    pktLenT  length;
    payloadT payload;
  } flitT;

  typedef struct packed {
    flitT   flit;
    portIdT srcPort;
  } outFlitT;

  typedef enum portIdT {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portNameT;

  typedef enum logic [2:0] {
    IDLE,
    GRANT_L,
    GRANT_N,
    GRANT_E,
    GRANT_W,
    GRANT_S
  } arbStateT;

endpackage
